//--- coco_pkg.sv
// ===========================================================================
// Shared widths, addresses and settings layout for the glue layer
// ===========================================================================
package coco_pkg;

	// Settings word and APB geometry
	localparam int STATUS_W   = 64;
	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 32;

	// Byte addresses of the two settings halves
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS_LO = 4'h0;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS_HI = 4'h4;

	// Tape image RAM, 64 KiB
	localparam int TAPE_ADDR_W = 16;

	// Joystick words
	localparam int JOY_W  = 32;
	localparam int AJOY_W = 16;

	// Signed axis to unsigned centre
	localparam logic [7:0] AXIS_OFFSET = 8'd128;

	// Download slot that carries a cassette image
	localparam logic [7:0] TAPE_INDEX = 8'd2;

	// Field view of the settings word, MSB first
	typedef struct packed {
		logic [24:0] spare_63_39;
		logic [1:0]  artifact;
		logic [8:0]  spare_36_28;
		logic [2:0]  mem_size;
		logic [1:0]  spare_24_23;
		logic        coldboot;
		logic        sg_mode;
		logic [2:0]  spare_20_18;
		logic        monitor;
		logic        cart_int;
		logic        rewind;
		logic        video;
		logic [1:0]  mpi;
		logic        cpu_speed;
		logic        spare_10;
		logic [1:0]  aspect;
		logic        spare_7;
		logic        swap;
		logic [2:0]  scandoubler;
		logic [1:0]  spare_2_1;
		logic        reset;
	} status_fields_t;

	// Same 64 bits, seen as raw, as bus halves or as fields
	typedef union packed {
		logic [STATUS_W-1:0]          raw;
		logic [1:0][APB_DATA_W-1:0]   half;
		status_fields_t               f;
	} status_word_u;

endpackage

//--- cfg_if.sv
`timescale 1ns/1ps

// ===========================================================================
// Decoded settings from the register block to the core glue
// ===========================================================================
interface cfg_if;

	// Player swap for the joystick router
	logic       swap;

	// Tape controls
	logic       rewind;
	logic       monitor;

	// Multi-Pak slot, already 1-based
	logic [1:0] mpi;

	// Memory size selector
	logic [2:0] mem_size;

	// Boot controls
	logic       coldboot;
	logic       soft_reset;

	modport producer (
		output swap,
		output rewind,
		output monitor,
		output mpi,
		output mem_size,
		output coldboot,
		output soft_reset
	);

	modport consumer (
		input swap,
		input rewind,
		input monitor,
		input mpi,
		input mem_size,
		input coldboot,
		input soft_reset
	);

endinterface

//--- status_regs.sv
`timescale 1ns/1ps

module status_regs (
	input  logic                            clk_sys,
	input  logic                            arst_n,

	// APB slave
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [coco_pkg::APB_ADDR_W-1:0] paddr,
	input  logic [coco_pkg::APB_DATA_W-1:0] pwdata,
	output logic [coco_pkg::APB_DATA_W-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr,

	// Decoded settings
	cfg_if.producer                         cfg,
	output logic [12:0]                     video_arx,
	output logic [12:0]                     video_ary,
	output logic [1:0]                      vga_sl,
	output logic [9:0]                      core_switch
);

	coco_pkg::status_word_u status_q;

	logic hit_lo;
	logic hit_hi;
	logic access;
	logic [2:0] sl_full;
	logic [1:0] mpi_slot;

	// ========================================================================
	// APB access
	// ========================================================================

	assign hit_lo = (paddr == coco_pkg::ADDR_STATUS_LO);
	assign hit_hi = (paddr == coco_pkg::ADDR_STATUS_HI);
	assign access = psel & penable;

	// Never stalls
	assign pready = 1'b1;

	// Unmapped address flagged in access phase only
	assign pslverr = access & ~(hit_lo | hit_hi);

	always_comb
	begin
		prdata = '0;
		if (hit_lo)
			prdata = status_q.half[0];
		else if (hit_hi)
			prdata = status_q.half[1];
	end

	// Write lands on the edge closing the access phase
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			status_q.raw <= '0;
		else if (access && pwrite)
		begin
			if (hit_lo)
				status_q.half[0] <= pwdata;
			else if (hit_hi)
				status_q.half[1] <= pwdata;
		end
	end

	// ========================================================================
	// Field decode
	// ========================================================================

	// Menu stores slot minus one
	assign mpi_slot = status_q.f.mpi + 2'd1;

	assign cfg.swap       = status_q.f.swap;
	assign cfg.rewind     = status_q.f.rewind;
	assign cfg.monitor    = status_q.f.monitor;
	assign cfg.mpi        = mpi_slot;
	assign cfg.mem_size   = status_q.f.mem_size;
	assign cfg.coldboot   = status_q.f.coldboot;
	assign cfg.soft_reset = status_q.f.reset;

	// Original 4:3, else preset index into the scaler
	assign video_arx = (status_q.f.aspect == 2'd0) ? 13'd4
		: {11'd0, status_q.f.aspect - 2'd1};
	assign video_ary = (status_q.f.aspect == 2'd0) ? 13'd3 : 13'd0;

	// Scanline strength, entry 1 is HQ2x with no lines
	assign sl_full = (status_q.f.scandoubler == 3'd0) ? 3'd0
		: status_q.f.scandoubler - 3'd1;
	assign vga_sl  = sl_full[1:0];

	// Top two bits fixed, serial ports not swapped
	assign core_switch = {
		2'b10,
		status_q.f.artifact,
		status_q.f.sg_mode,
		status_q.f.cart_int,
		status_q.f.video,
		mpi_slot,
		status_q.f.cpu_speed
	};

endmodule

//--- boot_control.sv
`timescale 1ns/1ps

module boot_control (
	input  logic    clk_sys,
	input  logic    arst_n,
	input  logic    ext_reset,
	input  logic    button_user,
	cfg_if.consumer cfg,
	output logic    core_reset_n,
	output logic    amw_trigger
);

	// Delayed copies for edge detection
	logic [1:0] mpi_d;
	logic [2:0] mem_d;

	// Copies hold real values from the second cycle on
	logic       armed_q;

	// Index 0 tracks mpi, index 1 tracks mem_size
	logic [1:0] first_q;
	logic [1:0] pulse_q;
	logic [1:0] changed;

	assign changed = {cfg.mem_size != mem_d, cfg.mpi != mpi_d};

	// ========================================================================
	// Change detection and trigger pulse
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mpi_d   <= '0;
			mem_d   <= '0;
			armed_q <= 1'b0;
			first_q <= '0;
			pulse_q <= '0;
		end
		else
		begin
			mpi_d   <= cfg.mpi;
			mem_d   <= cfg.mem_size;
			armed_q <= 1'b1;
			for (int i = 0; i < 2; i++)
			begin
				pulse_q[i] <= 1'b0;
				// First edit after reset only arms the detector
				if (armed_q && changed[i])
				begin
					if (first_q[i])
						pulse_q[i] <= 1'b1;
					else
						first_q[i] <= 1'b1;
				end
			end
		end
	end

	// Cold boot setting holds the trigger
	assign amw_trigger = cfg.coldboot | (|pulse_q);

	// Any source pulls the core into reset
	assign core_reset_n = ~(ext_reset | cfg.soft_reset | button_user);

endmodule

//--- joy_router.sv
`timescale 1ns/1ps

module joy_router (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	cfg_if.consumer                     cfg,
	input  logic [coco_pkg::JOY_W-1:0]  joy1_in,
	input  logic [coco_pkg::JOY_W-1:0]  joy2_in,
	input  logic [coco_pkg::AJOY_W-1:0] ajoy1_in,
	input  logic [coco_pkg::AJOY_W-1:0] ajoy2_in,
	output logic [coco_pkg::JOY_W-1:0]  joy1,
	output logic [coco_pkg::JOY_W-1:0]  joy2,
	output logic [coco_pkg::AJOY_W-1:0] ajoy1,
	output logic [coco_pkg::AJOY_W-1:0] ajoy2,
	output logic [3:0]                  p_switch
);

	logic [coco_pkg::AJOY_W-1:0] ajoy1_c;
	logic [coco_pkg::AJOY_W-1:0] ajoy2_c;

	// Both axis bytes shifted to unsigned, wraps mod 256
	function automatic logic [coco_pkg::AJOY_W-1:0] centre(
		input logic [coco_pkg::AJOY_W-1:0] a
	);
		centre = {a[15:8] + coco_pkg::AXIS_OFFSET, a[7:0] + coco_pkg::AXIS_OFFSET};
	endfunction

	assign ajoy1_c = centre(ajoy1_in);
	assign ajoy2_c = centre(ajoy2_in);

	// Registered player swap
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			joy1  <= '0;
			joy2  <= '0;
			ajoy1 <= '0;
			ajoy2 <= '0;
		end
		else
		begin
			joy1  <= cfg.swap ? joy2_in : joy1_in;
			joy2  <= cfg.swap ? joy1_in : joy2_in;
			ajoy1 <= cfg.swap ? ajoy2_c : ajoy1_c;
			ajoy2 <= cfg.swap ? ajoy1_c : ajoy2_c;
		end
	end

	// Active-low fire buttons, order R1 L2 R2 L1
	assign p_switch = ~{joy2[4], joy1[5], joy2[5], joy1[4]};

endmodule

//--- tape_player.sv
`timescale 1ns/1ps

module tape_player (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	cfg_if.consumer                          cfg,

	// Byte download
	input  logic                             dl_active,
	input  logic                             dl_wr,
	input  logic [7:0]                       dl_index,
	input  logic [coco_pkg::TAPE_ADDR_W-1:0] dl_addr,
	input  logic [7:0]                       dl_data,

	// Playback
	input  logic                             motor,
	input  logic                             q_tick,
	input  logic [15:0]                      audio_in,
	output logic                             cas_bit,
	output logic [15:0]                      audio_out
);

	// Tape image storage
	logic [7:0] tape_mem [2**coco_pkg::TAPE_ADDR_W];

	logic                             tape_wr;
	logic [coco_pkg::TAPE_ADDR_W-1:0] ram_addr;
	logic [7:0]                       rd_data;

	// Bit pointer, byte address above a 3-bit index
	logic [coco_pkg::TAPE_ADDR_W+2:0] bit_ptr;
	logic [coco_pkg::TAPE_ADDR_W-1:0] byte_ptr;
	logic [2:0]                       bit_idx;
	logic [2:0]                       rd_idx;

	// Remaining bits of the current byte, next bit at the top
	logic [7:0]                       shift_q;
	logic                             loaded_q;

	// ========================================================================
	// RAM and loader
	// ========================================================================

	assign tape_wr  = dl_wr && (dl_index == coco_pkg::TAPE_INDEX);
	assign byte_ptr = bit_ptr[coco_pkg::TAPE_ADDR_W+2:3];
	assign bit_idx  = bit_ptr[2:0];

	// Loader owns the address while a download runs
	assign ram_addr = dl_active ? dl_addr : byte_ptr;

	always_ff @(posedge clk_sys)
	begin
		if (tape_wr)
			tape_mem[dl_addr] <= dl_data;
		rd_data <= tape_mem[ram_addr];
		// Index travels with the byte it selects from
		rd_idx  <= bit_idx;
	end

	// ========================================================================
	// Playback
	// ========================================================================

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bit_ptr  <= '0;
			loaded_q <= 1'b0;
			shift_q  <= '0;
		end
		else
		begin
			if (tape_wr)
				loaded_q <= 1'b1;

			// Back to the start of the image
			if (cfg.rewind || dl_active || tape_wr)
				bit_ptr <= '0;
			else if (q_tick && motor)
				bit_ptr <= bit_ptr + 1'b1;

			// Line stays low until an image exists
			if (loaded_q)
				shift_q <= rd_data << rd_idx;
			else
				shift_q <= '0;
		end
	end

	// MSB first
	assign cas_bit = shift_q[7];

	// Tape monitor mixed into bit 13
	assign audio_out = {audio_in[15:14], audio_in[13] ^ (cfg.monitor & cas_bit),
		audio_in[12:0]};

endmodule

//--- coco_glue_top.sv
`timescale 1ns/1ps

module coco_glue_top (
	input  logic                             clk_sys,
	input  logic                             arst_n,

	// APB settings port
	input  logic                             psel,
	input  logic                             penable,
	input  logic                             pwrite,
	input  logic [coco_pkg::APB_ADDR_W-1:0]  paddr,
	input  logic [coco_pkg::APB_DATA_W-1:0]  pwdata,
	output logic [coco_pkg::APB_DATA_W-1:0]  prdata,
	output logic                             pready,
	output logic                             pslverr,

	// Video and core switches
	output logic [12:0]                      video_arx,
	output logic [12:0]                      video_ary,
	output logic [1:0]                       vga_sl,
	output logic [9:0]                       core_switch,

	// Boot
	input  logic                             ext_reset,
	input  logic                             button_user,
	output logic                             core_reset_n,
	output logic                             amw_trigger,

	// Joysticks
	input  logic [coco_pkg::JOY_W-1:0]       joy1_in,
	input  logic [coco_pkg::JOY_W-1:0]       joy2_in,
	input  logic [coco_pkg::AJOY_W-1:0]      ajoy1_in,
	input  logic [coco_pkg::AJOY_W-1:0]      ajoy2_in,
	output logic [coco_pkg::JOY_W-1:0]       joy1,
	output logic [coco_pkg::JOY_W-1:0]       joy2,
	output logic [coco_pkg::AJOY_W-1:0]      ajoy1,
	output logic [coco_pkg::AJOY_W-1:0]      ajoy2,
	output logic [3:0]                       p_switch,

	// Download and cassette
	input  logic                             dl_active,
	input  logic                             dl_wr,
	input  logic [7:0]                       dl_index,
	input  logic [coco_pkg::TAPE_ADDR_W-1:0] dl_addr,
	input  logic [7:0]                       dl_data,
	input  logic                             motor,
	input  logic                             q_tick,
	input  logic [15:0]                      audio_in,
	output logic                             cas_bit,
	output logic [15:0]                      audio_out
);

	// Decoded settings bundle
	cfg_if cfg ();

	status_regs u_status_regs (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.cfg         (cfg.producer),
		.video_arx   (video_arx),
		.video_ary   (video_ary),
		.vga_sl      (vga_sl),
		.core_switch (core_switch)
	);

	boot_control u_boot_control (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.ext_reset    (ext_reset),
		.button_user  (button_user),
		.cfg          (cfg.consumer),
		.core_reset_n (core_reset_n),
		.amw_trigger  (amw_trigger)
	);

	joy_router u_joy_router (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.cfg      (cfg.consumer),
		.joy1_in  (joy1_in),
		.joy2_in  (joy2_in),
		.ajoy1_in (ajoy1_in),
		.ajoy2_in (ajoy2_in),
		.joy1     (joy1),
		.joy2     (joy2),
		.ajoy1    (ajoy1),
		.ajoy2    (ajoy2),
		.p_switch (p_switch)
	);

	tape_player u_tape_player (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cfg       (cfg.consumer),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.motor     (motor),
		.q_tick    (q_tick),
		.audio_in  (audio_in),
		.cas_bit   (cas_bit),
		.audio_out (audio_out)
	);

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	// 100 MHz system clock
	initial
	begin
		clk_sys = 1'b0;
		forever
			#5 clk_sys = ~clk_sys;
	end

	// Reset held for five rising edges, released just after the fifth
	initial
	begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
	end

endmodule

//--- tb_coco_glue.sv
`timescale 1ns/1ps

module tb_coco_glue;

	localparam int APB_TIMEOUT = 16;
	localparam int RST_TIMEOUT = 50;

	logic                             clk_sys;
	logic                             arst_n;

	// APB
	logic                             psel;
	logic                             penable;
	logic                             pwrite;
	logic [coco_pkg::APB_ADDR_W-1:0]  paddr;
	logic [coco_pkg::APB_DATA_W-1:0]  pwdata;
	logic [coco_pkg::APB_DATA_W-1:0]  prdata;
	logic                             pready;
	logic                             pslverr;

	// Video, switches, boot
	logic [12:0]                      video_arx;
	logic [12:0]                      video_ary;
	logic [1:0]                       vga_sl;
	logic [9:0]                       core_switch;
	logic                             ext_reset;
	logic                             button_user;
	logic                             core_reset_n;
	logic                             amw_trigger;

	// Joysticks
	logic [coco_pkg::JOY_W-1:0]       joy1_in;
	logic [coco_pkg::JOY_W-1:0]       joy2_in;
	logic [coco_pkg::AJOY_W-1:0]      ajoy1_in;
	logic [coco_pkg::AJOY_W-1:0]      ajoy2_in;
	logic [coco_pkg::JOY_W-1:0]       joy1;
	logic [coco_pkg::JOY_W-1:0]       joy2;
	logic [coco_pkg::AJOY_W-1:0]      ajoy1;
	logic [coco_pkg::AJOY_W-1:0]      ajoy2;
	logic [3:0]                       p_switch;

	// Download and cassette
	logic                             dl_active;
	logic                             dl_wr;
	logic [7:0]                       dl_index;
	logic [coco_pkg::TAPE_ADDR_W-1:0] dl_addr;
	logic [7:0]                       dl_data;
	logic                             motor;
	logic                             q_tick;
	logic [15:0]                      audio_in;
	logic                             cas_bit;
	logic [15:0]                      audio_out;

	// Reference copy of the downloaded image
	logic [7:0] tape_img [8];

	tb_clock clk_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	coco_glue_top dut0 (.*);

	// ========================================================================
	// Failure reporting and compares
	// ========================================================================

	task automatic fail_stop();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out while waiting for %s", what);
		fail_stop();
	endtask

	task automatic word_equal(
		input logic [coco_pkg::APB_DATA_W-1:0] got,
		input logic [coco_pkg::APB_DATA_W-1:0] exp,
		input string                           what
	);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_stop();
		end
	endtask

	task automatic bit_equal(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			fail_stop();
		end
	endtask

	task automatic half_equal(
		input logic [coco_pkg::AJOY_W-1:0] got,
		input logic [coco_pkg::AJOY_W-1:0] exp,
		input string                       what
	);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			fail_stop();
		end
	endtask

	// ========================================================================
	// Bus helpers
	// ========================================================================

	// Inputs change 1 ns after the rising edge
	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic bus_transfer(
		input  logic                            wr,
		input  logic [coco_pkg::APB_ADDR_W-1:0] addr,
		input  logic [coco_pkg::APB_DATA_W-1:0] wdata,
		output logic [coco_pkg::APB_DATA_W-1:0] rdata,
		output logic                            err
	);
		int n;
		// Setup phase
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		step_cycle();
		// Access phase, sampled mid-cycle
		penable = 1'b1;
		n = 0;
		#4;
		while (pready !== 1'b1)
		begin
			if (n >= APB_TIMEOUT)
				timeout_fail("pready");
			step_cycle();
			#4;
			n++;
		end
		rdata = prdata;
		err   = pslverr;
		// Write lands on this edge
		step_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic write_reg(
		input logic [coco_pkg::APB_ADDR_W-1:0] addr,
		input logic [coco_pkg::APB_DATA_W-1:0] data
	);
		logic [coco_pkg::APB_DATA_W-1:0] rd;
		logic err;
		bus_transfer(1'b1, addr, data, rd, err);
		bit_equal(err, 1'b0, "pslverr on register write");
	endtask

	task automatic read_reg(
		input  logic [coco_pkg::APB_ADDR_W-1:0] addr,
		output logic [coco_pkg::APB_DATA_W-1:0] data
	);
		logic err;
		bus_transfer(1'b0, addr, '0, data, err);
		bit_equal(err, 1'b0, "pslverr on register read");
	endtask

	// Trigger level held for a number of cycles
	task automatic hold_trigger(input logic level, input int cycles, input string what);
		for (int i = 0; i < cycles; i++)
		begin
			bit_equal(amw_trigger, level, what);
			step_cycle();
		end
	endtask

	// Low now, high for one cycle, then low again
	task automatic single_pulse(input string what);
		bit_equal(amw_trigger, 1'b0, what);
		step_cycle();
		bit_equal(amw_trigger, 1'b1, what);
		step_cycle();
		bit_equal(amw_trigger, 1'b0, what);
		step_cycle();
		bit_equal(amw_trigger, 1'b0, what);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	// Settings word is zero out of reset
	task automatic reset_defaults();
		bit_equal(pslverr, 1'b0, "pslverr after reset");
		bit_equal(cas_bit, 1'b0, "cas_bit after reset");
		half_equal({3'd0, video_arx}, 16'd4, "video_arx after reset");
		half_equal({3'd0, video_ary}, 16'd3, "video_ary after reset");
		half_equal({14'd0, vga_sl}, 16'd0, "vga_sl after reset");
		// Fixed 2'b10 on top, mpi slot 1 at bits 2..1
		half_equal({6'd0, core_switch}, 16'h0202, "core_switch after reset");
	endtask

	// mpi at bits 13..12, mem_size at 27..25, coldboot bit 22, reset bit 0
	task automatic boot_sequence();
		bit_equal(amw_trigger, 1'b0, "amw_trigger after reset");
		bit_equal(core_reset_n, 1'b1, "core_reset_n after reset");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0000_1000);
		hold_trigger(1'b0, 4, "amw_trigger on first mpi change");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0000_2000);
		single_pulse("amw_trigger on second mpi change");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0200_2000);
		hold_trigger(1'b0, 4, "amw_trigger on first mem_size change");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0400_2000);
		single_pulse("amw_trigger on second mem_size change");
		// Cold boot holds the trigger
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0440_2000);
		hold_trigger(1'b1, 4, "amw_trigger with coldboot");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0400_2000);
		hold_trigger(1'b0, 2, "amw_trigger after coldboot");
		// Each reset source in turn
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0400_2001);
		bit_equal(core_reset_n, 1'b0, "core_reset_n with soft_reset");
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0400_2000);
		bit_equal(core_reset_n, 1'b1, "core_reset_n after soft_reset");
		ext_reset = 1'b1;
		step_cycle();
		bit_equal(core_reset_n, 1'b0, "core_reset_n with ext_reset");
		ext_reset = 1'b0;
		button_user = 1'b1;
		step_cycle();
		bit_equal(core_reset_n, 1'b0, "core_reset_n with button_user");
		button_user = 1'b0;
		step_cycle();
		bit_equal(core_reset_n, 1'b1, "core_reset_n with no source");
	endtask

	task automatic apb_readback();
		logic [coco_pkg::APB_DATA_W-1:0] lo;
		logic [coco_pkg::APB_DATA_W-1:0] hi;
		logic [coco_pkg::APB_DATA_W-1:0] rd;
		logic err;
		repeat (3)
		begin
			lo = $urandom();
			hi = $urandom();
			write_reg(coco_pkg::ADDR_STATUS_LO, lo);
			write_reg(coco_pkg::ADDR_STATUS_HI, hi);
			read_reg(coco_pkg::ADDR_STATUS_LO, rd);
			word_equal(rd, lo, "low settings half");
			read_reg(coco_pkg::ADDR_STATUS_HI, rd);
			word_equal(rd, hi, "high settings half");
			// Unmapped address errors and leaves the word alone
			bus_transfer(1'b1, 4'h8, $urandom(), rd, err);
			bit_equal(err, 1'b1, "pslverr on write to 0x8");
			bus_transfer(1'b0, 4'h8, '0, rd, err);
			bit_equal(err, 1'b1, "pslverr on read from 0x8");
			read_reg(coco_pkg::ADDR_STATUS_LO, rd);
			word_equal(rd, lo, "low half after unmapped write");
			read_reg(coco_pkg::ADDR_STATUS_HI, rd);
			word_equal(rd, hi, "high half after unmapped write");
		end
	endtask

	task automatic decode_fields();
		logic [1:0]  asp [3] = '{2'd0, 2'd1, 2'd3};
		logic [12:0] arx_tab [3] = '{13'd4, 13'd0, 13'd2};
		logic [12:0] ary_tab [3] = '{13'd3, 13'd0, 13'd0};
		logic [2:0]  scans [2] = '{3'd0, 3'd4};
		logic [1:0]  sl_tab [2] = '{2'd0, 2'd3};
		logic [1:0]  a;
		logic [2:0]  s;
		logic [15:0] exp_sw;
		write_reg(coco_pkg::ADDR_STATUS_HI, '0);
		foreach (asp[i])
		begin
			foreach (scans[j])
			begin
				a = asp[i];
				s = scans[j];
				// aspect at 9..8, scandoubler at 5..3
				write_reg(coco_pkg::ADDR_STATUS_LO, {22'd0, a, 2'd0, s, 3'd0});
				half_equal({3'd0, video_arx}, {3'd0, arx_tab[i]}, "video_arx");
				half_equal({3'd0, video_ary}, {3'd0, ary_tab[i]}, "video_ary");
				half_equal({14'd0, vga_sl}, {14'd0, sl_tab[j]}, "vga_sl");
			end
		end
		// cpu_speed 1, mpi 2, video 1, cart_int 0, sg_mode 1
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0020_6800);
		// artifact 01 at bits 38..37
		write_reg(coco_pkg::ADDR_STATUS_HI, 32'h0000_0020);
		// Menu value 2 is slot 3
		exp_sw = {6'd0, 2'b10, 2'b01, 1'b1, 1'b0, 1'b1, 2'd3, 1'b1};
		half_equal({6'd0, core_switch}, exp_sw, "core_switch");
		write_reg(coco_pkg::ADDR_STATUS_HI, '0);
	endtask

	task automatic joystick_routing();
		logic [coco_pkg::JOY_W-1:0]  e1;
		logic [coco_pkg::JOY_W-1:0]  e2;
		logic [coco_pkg::AJOY_W-1:0] c1;
		logic [coco_pkg::AJOY_W-1:0] c2;
		logic                        sw;
		for (int k = 0; k < 2; k++)
		begin
			// swap is bit 6
			sw = k[0];
			write_reg(coco_pkg::ADDR_STATUS_LO, {25'd0, sw, 6'd0});
			repeat (4)
			begin
				joy1_in  = $urandom();
				joy2_in  = $urandom();
				ajoy1_in = 16'($urandom());
				ajoy2_in = 16'($urandom());
				// Adding 128 to a byte modulo 256 only flips its top bit
				c1 = ajoy1_in ^ 16'h8080;
				c2 = ajoy2_in ^ 16'h8080;
				e1 = sw ? joy2_in : joy1_in;
				e2 = sw ? joy1_in : joy2_in;
				step_cycle();
				word_equal(joy1, e1, "joy1");
				word_equal(joy2, e2, "joy2");
				half_equal(ajoy1, sw ? c2 : c1, "ajoy1");
				half_equal(ajoy2, sw ? c1 : c2, "ajoy2");
				half_equal({12'd0, p_switch},
					{12'd0, ~{e2[4], e1[5], e2[5], e1[4]}}, "p_switch");
			end
		end
	endtask

	task automatic tape_playback();
		logic        exp_bit;
		logic [15:0] au;
		int          p;
		write_reg(coco_pkg::ADDR_STATUS_LO, '0);
		// Eight random bytes into the tape slot
		dl_active = 1'b1;
		dl_index  = coco_pkg::TAPE_INDEX;
		step_cycle();
		for (int i = 0; i < 8; i++)
		begin
			tape_img[i] = 8'($urandom());
			// First bit set so the monitor mix sees a one
			if (i == 0)
				tape_img[i][7] = 1'b1;
			dl_addr = i;
			dl_data = tape_img[i];
			dl_wr   = 1'b1;
			step_cycle();
		end
		dl_wr     = 1'b0;
		dl_active = 1'b0;
		step_cycle();
		// Rewind is bit 15
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0000_8000);
		write_reg(coco_pkg::ADDR_STATUS_LO, '0);
		step_cycle();
		step_cycle();
		bit_equal(cas_bit, tape_img[0][7], "cas_bit after rewind");
		motor = 1'b1;
		for (int k = 0; k < 64; k++)
		begin
			q_tick = 1'b1;
			step_cycle();
			q_tick = 1'b0;
			repeat (3) step_cycle();
			p = k + 1;
			// Last pulse moves past the image
			if (p < 64)
				bit_equal(cas_bit, tape_img[p / 8][7 - p % 8], "cas_bit during playback");
			// Ticks with the relay open must not move the pointer
			if (k == 31)
			begin
				motor = 1'b0;
				repeat (3)
				begin
					q_tick = 1'b1;
					step_cycle();
					q_tick = 1'b0;
					repeat (3) step_cycle();
					bit_equal(cas_bit, tape_img[p / 8][7 - p % 8], "cas_bit with motor off");
				end
				motor = 1'b1;
			end
		end
		motor = 1'b0;
		// Monitor is bit 17, rewound to the first bit
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0002_8000);
		write_reg(coco_pkg::ADDR_STATUS_LO, 32'h0002_0000);
		step_cycle();
		step_cycle();
		exp_bit = tape_img[0][7];
		bit_equal(cas_bit, exp_bit, "cas_bit before monitor check");
		repeat (4)
		begin
			au = 16'($urandom());
			audio_in = au;
			step_cycle();
			half_equal(audio_out, au ^ {2'b00, exp_bit, 13'd0}, "audio_out with monitor");
		end
		write_reg(coco_pkg::ADDR_STATUS_LO, '0);
		half_equal(audio_out, au, "audio_out without monitor");
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial
	begin
		int n;
		void'($urandom(32'heeab));
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		ext_reset   = 1'b0;
		button_user = 1'b0;
		joy1_in     = '0;
		joy2_in     = '0;
		ajoy1_in    = '0;
		ajoy2_in    = '0;
		dl_active   = 1'b0;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		motor       = 1'b0;
		q_tick      = 1'b0;
		audio_in    = '0;
		n = 0;
		while (arst_n !== 1'b1)
		begin
			if (n >= RST_TIMEOUT)
				timeout_fail("reset release");
			@(posedge clk_sys);
			n++;
		end
		#1;
		reset_defaults();
		// Boot first, while mpi and mem_size are untouched
		boot_sequence();
		apb_readback();
		decode_fields();
		joystick_routing();
		tape_playback();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- project.f
coco_pkg.sv
cfg_if.sv
status_regs.sv
boot_control.sv
joy_router.sv
tape_player.sv
coco_glue_top.sv
tb_clock.sv
tb_coco_glue.sv

//--- Bender.yml
package:
  name: coco_glue

sources:
  - coco_pkg.sv
  - cfg_if.sv
  - status_regs.sv
  - boot_control.sv
  - joy_router.sv
  - tape_player.sv
  - coco_glue_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_coco_glue.sv
